// ==== common/histDefs.svh ====
`ifndef HIST_DEFS_SVH
`define HIST_DEFS_SVH

// array size
`define HIST_PIXELS 4
`define HIST_BINS 16

// widths of the pixel and bin numbers
`define HIST_PIX_W 2
`define HIST_BIN_W 4

// one histogram count, saturates at all ones
`define HIST_COUNT_W 8

// memory address is {pixel, bin}
`define HIST_ADDR_W (`HIST_PIX_W + `HIST_BIN_W)

`endif

// ==== common/histPkg.sv ====
`include "histDefs.svh"

package histPkg;

    // hit coordinates
    typedef logic [`HIST_PIX_W-1:0] pixelT;
    typedef logic [`HIST_BIN_W-1:0] binT;

    // histogram payload
    typedef logic [`HIST_COUNT_W-1:0] countT;

    // pixel in the upper bits, bin in the lower bits
    typedef logic [`HIST_ADDR_W-1:0] ramAddrT;

    // one result per pixel readout
    typedef struct packed {
        pixelT pixel;
        binT bin;
        countT count;
        logic found;
    } peakT;

    // register select
    typedef logic [1:0] cfgAddrT;

    localparam cfgAddrT CFG_ENABLE = 2'd0;
    localparam cfgAddrT CFG_CLEAR = 2'd1;
    localparam cfgAddrT CFG_THRESH = 2'd2;

endpackage

// ==== common/histRamIf.sv ====
`timescale 1ns/100ps

// one port of the histogram memory
interface histRamIf;

    // read side, data returns one cycle after rdEn
    logic rdEn;
    histPkg::ramAddrT rdAddr;
    histPkg::countT rdData;

    // write side
    logic wrEn;
    histPkg::ramAddrT wrAddr;
    histPkg::countT wrData;

    modport client (
        output rdEn,
        output rdAddr,
        input rdData,
        output wrEn,
        output wrAddr,
        output wrData
    );

    modport memory (
        input rdEn,
        input rdAddr,
        output rdData,
        input wrEn,
        input wrAddr,
        input wrData
    );

endinterface

// ==== files.f ====
+incdir+common
common/histPkg.sv
common/histRamIf.sv
hw/histRam.sv
hw/histConfig.sv
histBuilder/histBuilder.sv
peakFinder/peakFinder.sv
hw/histTop.sv
tests/histTb.sv

// ==== histBuilder/histBuilder.sv ====
`timescale 1ns/100ps
`include "histDefs.svh"

module histBuilder (
    input logic clk,
    input logic res,
    input logic hitValid,
    input histPkg::pixelT hitPixel,
    input histPkg::binT hitBin,
    input logic histEnable,
    input logic scanBusy,
    histRamIf.client ram
);

    localparam histPkg::countT COUNT_MAX = {`HIST_COUNT_W{1'b1}};

    // hit stage
    logic hitAccept;
    histPkg::ramAddrT hitAddr;

    // read stage, memory data arrives here
    logic rdValid;
    histPkg::ramAddrT rdAddrQ;

    // last written bin, kept for forwarding
    logic wrValid;
    histPkg::ramAddrT wrAddrQ;
    histPkg::countT wrCountQ;

    // increment path
    logic fwdSel;
    histPkg::countT baseCount;
    histPkg::countT nextCount;

    // drop hits while disabled or during readout
    assign hitAccept = hitValid && histEnable && !scanBusy;
    assign hitAddr = {hitPixel, hitBin};

    // read issued on the hit cycle itself
    assign ram.rdEn = hitAccept;
    assign ram.rdAddr = hitAddr;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rdValid <= 1'b0;
        end else begin
            rdValid <= hitAccept;
        end
    end

    always_ff @(posedge clk) begin
        rdAddrQ <= hitAddr;
    end

    // back-to-back hits on one bin
    // memory still holds the old count because it is read-first
    assign fwdSel = wrValid && (wrAddrQ == rdAddrQ);
    assign baseCount = fwdSel ? wrCountQ : ram.rdData;

    // saturate instead of wrapping
    assign nextCount = (baseCount == COUNT_MAX) ? baseCount : baseCount + 1'b1;

    // write back one edge after the read
    // a hit taken on the edge where the scan starts is lost here
    assign ram.wrEn = rdValid && !scanBusy;
    assign ram.wrAddr = rdAddrQ;
    assign ram.wrData = nextCount;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wrValid <= 1'b0;
        end else begin
            wrValid <= ram.wrEn;
        end
    end

    // value just written, replaces stale read data next cycle
    always_ff @(posedge clk) begin
        wrAddrQ <= rdAddrQ;
        wrCountQ <= nextCount;
    end

    // a second write to one bin builds on the first, unless saturated
    assert property (@(posedge clk) disable iff (!res)
        ram.wrEn && $past(ram.wrEn) && (ram.wrAddr == $past(ram.wrAddr))
            |-> (ram.wrData > $past(ram.wrData)) || (ram.wrData == COUNT_MAX))
        else $error("histBuilder: count not advanced on back-to-back write");

endmodule

// ==== hw/histConfig.sv ====
`timescale 1ns/100ps

module histConfig (
    input logic clk,
    input logic res,
    input logic cfgWrite,
    input histPkg::cfgAddrT cfgAddr,
    input histPkg::countT cfgData,
    output logic histEnable,
    output logic clearOnRead,
    output histPkg::countT peakThreshold
);

    // write strobe decode
    logic wrEnable;
    logic wrClear;
    logic wrThresh;

    assign wrEnable = cfgWrite && (cfgAddr == histPkg::CFG_ENABLE);
    assign wrClear = cfgWrite && (cfgAddr == histPkg::CFG_CLEAR);
    assign wrThresh = cfgWrite && (cfgAddr == histPkg::CFG_THRESH);

    // enable and clear-on-read both start set
    // threshold of 1 means any hit makes a peak
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            histEnable <= 1'b1;
            clearOnRead <= 1'b1;
            peakThreshold <= histPkg::countT'(1);
        end else begin
            // single-bit registers take bit 0
            if (wrEnable) begin
                histEnable <= cfgData[0];
            end
            if (wrClear) begin
                clearOnRead <= cfgData[0];
            end
            // full count width
            if (wrThresh) begin
                peakThreshold <= cfgData;
            end
        end
    end

endmodule

// ==== hw/histRam.sv ====
`timescale 1ns/100ps
`include "histDefs.svh"

module histRam (
    input logic clk,
    histRamIf.memory buildPort,
    histRamIf.memory scanPort,
    input logic scanBusy
);

    localparam int DEPTH = `HIST_PIXELS * `HIST_BINS;

    histPkg::countT mem [0:DEPTH-1];

    // selected client
    logic rdEn;
    histPkg::ramAddrT rdAddr;
    logic wrEn;
    histPkg::ramAddrT wrAddr;
    histPkg::countT wrData;
    histPkg::countT rdData;

    // all histograms start empty
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // scanner owns the memory for the whole readout
    always_comb begin
        if (scanBusy) begin
            rdEn = scanPort.rdEn;
            rdAddr = scanPort.rdAddr;
            wrEn = scanPort.wrEn;
            wrAddr = scanPort.wrAddr;
            wrData = scanPort.wrData;
        end else begin
            rdEn = buildPort.rdEn;
            rdAddr = buildPort.rdAddr;
            wrEn = buildPort.wrEn;
            wrAddr = buildPort.wrAddr;
            wrData = buildPort.wrData;
        end
    end

    // read-first, same address in one cycle returns the old count
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // only the selected client looks at it
    assign buildPort.rdData = rdData;
    assign scanPort.rdData = rdData;

    // a write on the idle port would be lost silently
    assert property (@(posedge clk)
        (scanBusy && !buildPort.wrEn) || (!scanBusy && !scanPort.wrEn))
        else $error("histRam: write on unselected port");

endmodule

// ==== hw/histTop.sv ====
`timescale 1ns/100ps

module histTop (
    input logic clk,
    input logic res,
    input logic hitValid,
    input histPkg::pixelT hitPixel,
    input histPkg::binT hitBin,
    input logic frameEnd,
    input logic cfgWrite,
    input histPkg::cfgAddrT cfgAddr,
    input histPkg::countT cfgData,
    output logic scanBusy,
    output logic peakValid,
    output histPkg::pixelT peakPixel,
    output histPkg::binT peakBin,
    output histPkg::countT peakCount,
    output logic peakFound
);

    // settings
    logic histEnable;
    logic clearOnRead;
    histPkg::countT peakThreshold;

    histPkg::peakT peakResult;

    // builder port and scan port
    histRamIf buildRam ();
    histRamIf scanRam ();

    histConfig config0 (
        .clk(clk),
        .res(res),
        .cfgWrite(cfgWrite),
        .cfgAddr(cfgAddr),
        .cfgData(cfgData),
        .histEnable(histEnable),
        .clearOnRead(clearOnRead),
        .peakThreshold(peakThreshold)
    );

    histBuilder builder0 (
        .clk(clk),
        .res(res),
        .hitValid(hitValid),
        .hitPixel(hitPixel),
        .hitBin(hitBin),
        .histEnable(histEnable),
        .scanBusy(scanBusy),
        .ram(buildRam.client)
    );

    histRam ram0 (
        .clk(clk),
        .buildPort(buildRam.memory),
        .scanPort(scanRam.memory),
        .scanBusy(scanBusy)
    );

    peakFinder finder0 (
        .clk(clk),
        .res(res),
        .frameEnd(frameEnd),
        .clearOnRead(clearOnRead),
        .peakThreshold(peakThreshold),
        .scanBusy(scanBusy),
        .peakValid(peakValid),
        .peakResult(peakResult),
        .ram(scanRam.client)
    );

    // result struct onto the pins
    assign peakPixel = peakResult.pixel;
    assign peakBin = peakResult.bin;
    assign peakCount = peakResult.count;
    assign peakFound = peakResult.found;

endmodule

// ==== peakFinder/peakFinder.sv ====
`timescale 1ns/100ps
`include "histDefs.svh"

module peakFinder (
    input logic clk,
    input logic res,
    input logic frameEnd,
    input logic clearOnRead,
    input histPkg::countT peakThreshold,
    output logic scanBusy,
    output logic peakValid,
    output histPkg::peakT peakResult,
    histRamIf.client ram
);

    typedef enum logic [1:0] {
        IDLE,
        DRAIN,
        SCAN,
        FLUSH
    } stateT;

    localparam histPkg::ramAddrT LAST_ADDR = histPkg::ramAddrT'(`HIST_PIXELS * `HIST_BINS - 1);
    localparam histPkg::binT LAST_BIN = histPkg::binT'(`HIST_BINS - 1);

    stateT state;
    logic drainDone;
    histPkg::ramAddrT scanAddr;

    // read data stage
    logic dataValid;
    histPkg::ramAddrT dataAddr;
    histPkg::pixelT dataPixel;
    histPkg::binT dataBin;
    logic lastBin;

    // running maximum of the current pixel
    histPkg::countT maxCount;
    histPkg::binT maxBin;
    logic takeNew;
    histPkg::countT bestCount;
    histPkg::binT bestBin;

    // frameEnd -> 2 cycles drain -> scan all addresses -> wait for last pulse
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= IDLE;
            drainDone <= 1'b0;
            scanAddr <= '0;
        end else begin
            case (state)
                IDLE: begin
                    drainDone <= 1'b0;
                    scanAddr <= '0;
                    if (frameEnd) begin
                        state <= DRAIN;
                    end
                end
                // lets the builder finish its in-flight writes
                DRAIN: begin
                    drainDone <= 1'b1;
                    if (drainDone) begin
                        state <= SCAN;
                    end
                end
                // one address per cycle, pixel order
                SCAN: begin
                    scanAddr <= scanAddr + 1'b1;
                    if (scanAddr == LAST_ADDR) begin
                        state <= FLUSH;
                    end
                end
                // hold busy over the final result pulse
                FLUSH: begin
                    if (peakValid) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign scanBusy = (state == SCAN) || (state == FLUSH);

    // read every bin, zero it in the same cycle
    // old count still comes back, memory is read-first
    assign ram.rdEn = (state == SCAN);
    assign ram.rdAddr = scanAddr;
    assign ram.wrEn = (state == SCAN) && clearOnRead;
    assign ram.wrAddr = scanAddr;
    assign ram.wrData = '0;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            dataValid <= 1'b0;
        end else begin
            dataValid <= ram.rdEn;
        end
    end

    always_ff @(posedge clk) begin
        dataAddr <= scanAddr;
    end

    assign dataBin = dataAddr[`HIST_BIN_W-1:0];
    assign dataPixel = dataAddr[`HIST_ADDR_W-1:`HIST_BIN_W];
    assign lastBin = dataValid && (dataBin == LAST_BIN);

    // bin 0 restarts the search
    // strict compare keeps the lowest bin on ties
    assign takeNew = (dataBin == '0) || (ram.rdData > maxCount);
    assign bestCount = takeNew ? ram.rdData : maxCount;
    assign bestBin = takeNew ? dataBin : maxBin;

    always_ff @(posedge clk) begin
        if (dataValid) begin
            maxCount <= bestCount;
            maxBin <= bestBin;
        end
    end

    // result one cycle after the pixel's last bin
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            peakValid <= 1'b0;
        end else begin
            peakValid <= lastBin;
        end
    end

    always_ff @(posedge clk) begin
        if (lastBin) begin
            peakResult.pixel <= dataPixel;
            peakResult.bin <= bestBin;
            peakResult.count <= bestCount;
            peakResult.found <= (bestCount >= peakThreshold);
        end
    end

    // results only come out inside a readout
    assert property (@(posedge clk) disable iff (!res)
        $rose(peakValid) |-> scanBusy)
        else $error("peakFinder: peak result outside readout");

endmodule

// ==== run.sh ====
#!/bin/bash
# builds and runs the histogram testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f files.f --top-module histTb \
        --Mdir obj_dir -o histSim; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/histSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ "$simStatus" -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "TEST PASS" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== tests/histTb.sv ====
`timescale 1ns/100ps
`include "histDefs.svh"

module histTb;

    localparam int COUNT_MAX = (1 << `HIST_COUNT_W) - 1;
    localparam int NUM_FRAMES = 9;
    localparam int SCAN_TIMEOUT = 400;

    // one frame of stimulus, pixel and bin only used for fixed hits
    typedef struct packed {
        logic [15:0] hits;
        logic randomHits;
        logic enable;
        logic clear;
        histPkg::countT thresh;
        histPkg::pixelT pixel;
        histPkg::binT bin;
    } frameT;

    logic clk = 1'b0;
    logic res;
    logic hitValid;
    histPkg::pixelT hitPixel;
    histPkg::binT hitBin;
    logic frameEnd;
    logic cfgWrite;
    histPkg::cfgAddrT cfgAddr;
    histPkg::countT cfgData;
    logic scanBusy;
    logic peakValid;
    histPkg::pixelT peakPixel;
    histPkg::binT peakBin;
    histPkg::countT peakCount;
    logic peakFound;

    frameT frames [NUM_FRAMES];
    // reference histograms
    int refHist [`HIST_PIXELS][`HIST_BINS];
    histPkg::peakT expPeaks [`HIST_PIXELS];
    logic [31:0] lcgState;
    // register values as the DUT should hold them
    logic enableShadow;
    logic clearShadow;
    histPkg::countT threshShadow;

    histTop dut0 (
        .clk(clk), .res(res),
        .hitValid(hitValid), .hitPixel(hitPixel), .hitBin(hitBin),
        .frameEnd(frameEnd),
        .cfgWrite(cfgWrite), .cfgAddr(cfgAddr), .cfgData(cfgData),
        .scanBusy(scanBusy), .peakValid(peakValid), .peakPixel(peakPixel),
        .peakBin(peakBin), .peakCount(peakCount), .peakFound(peakFound)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic failRun(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkPeak(input histPkg::peakT got, input histPkg::peakT exp);
        if (got.pixel !== exp.pixel) begin
            failRun($sformatf("Error: peakPixel 0x%h, expected 0x%h", got.pixel, exp.pixel));
        end
        if (got.bin !== exp.bin) begin
            failRun($sformatf("Error: peakBin 0x%h, expected 0x%h", got.bin, exp.bin));
        end
        if (got.count !== exp.count) begin
            failRun($sformatf("Error: peakCount 0x%h, expected 0x%h", got.count, exp.count));
        end
        if (got.found !== exp.found) begin
            failRun($sformatf("Error: peakFound 0x%h, expected 0x%h", got.found, exp.found));
        end
    endtask

    task automatic checkScan(input int pulses);
        if (pulses != `HIST_PIXELS) begin
            failRun($sformatf("Error: peakValid pulses 0x%h, expected 0x%h",
                pulses, `HIST_PIXELS));
        end
    endtask

    // peak of one pixel, strict compare so the lowest bin keeps a tie
    function automatic histPkg::peakT expectedPeak(input int pix);
        histPkg::peakT p;
        int best;
        int bestBin;
        best = refHist[pix][0];
        bestBin = 0;
        for (int b = 1; b < `HIST_BINS; b++) begin
            if (refHist[pix][b] > best) begin
                best = refHist[pix][b];
                bestBin = b;
            end
        end
        p.pixel = histPkg::pixelT'(pix);
        p.bin = histPkg::binT'(bestBin);
        p.count = histPkg::countT'(best);
        p.found = (best >= int'(threshShadow));
        return p;
    endfunction

    task automatic clearModel();
        for (int p = 0; p < `HIST_PIXELS; p++) begin
            for (int b = 0; b < `HIST_BINS; b++) begin
                refHist[p][b] = 0;
            end
        end
    endtask

    task automatic writeCfg(input histPkg::cfgAddrT a, input histPkg::countT d);
        @(posedge clk);
        cfgWrite <= 1'b1;
        cfgAddr <= a;
        cfgData <= d;
    endtask

    task automatic sendHit(input histPkg::pixelT p, input histPkg::binT b);
        @(posedge clk);
        hitValid <= 1'b1;
        hitPixel <= p;
        hitBin <= b;
        // disabled hits never reach memory
        if (enableShadow && refHist[p][b] < COUNT_MAX) begin
            refHist[p][b]++;
        end
    endtask

    task automatic idleCycle();
        @(posedge clk);
        hitValid <= 1'b0;
    endtask

    // frameEnd pulse, then collect one result per pixel
    task automatic readout();
        int waited;
        int pulses;
        histPkg::peakT got;
        @(posedge clk);
        frameEnd <= 1'b1;
        @(posedge clk);
        frameEnd <= 1'b0;
        waited = 0;
        while (!scanBusy && waited < SCAN_TIMEOUT) begin
            @(negedge clk);
            waited++;
            if (peakValid && !scanBusy) begin
                failRun("peakValid pulsed before scanBusy rose");
            end
        end
        if (!scanBusy) begin
            failRun("timeout waiting for scanBusy to rise after frameEnd");
        end
        pulses = 0;
        waited = 0;
        while (scanBusy && waited < SCAN_TIMEOUT) begin
            if (peakValid) begin
                got.pixel = peakPixel;
                got.bin = peakBin;
                got.count = peakCount;
                got.found = peakFound;
                // pixel order is checked through the pixel field
                if (pulses < `HIST_PIXELS) begin
                    checkPeak(got, expPeaks[pulses]);
                end
                pulses++;
            end
            @(negedge clk);
            waited++;
        end
        if (scanBusy) begin
            failRun("timeout waiting for scanBusy to fall at the end of the readout");
        end
        // no stray pulse once the readout is over
        repeat (4) begin
            if (peakValid) begin
                failRun("peakValid pulsed while scanBusy was low");
            end
            @(negedge clk);
        end
        checkScan(pulses);
    endtask

    task automatic runFrame(input frameT f);
        logic [31:0] r;
        writeCfg(histPkg::CFG_ENABLE, histPkg::countT'(f.enable));
        writeCfg(histPkg::CFG_CLEAR, histPkg::countT'(f.clear));
        writeCfg(histPkg::CFG_THRESH, f.thresh);
        @(posedge clk);
        cfgWrite <= 1'b0;
        enableShadow = f.enable;
        clearShadow = f.clear;
        threshShadow = f.thresh;
        for (int i = 0; i < int'(f.hits); i++) begin
            if (f.randomHits) begin
                lcgState = lcgNext(lcgState);
                r = lcgState;
                sendHit(r[31:30], r[27:24]);
                // occasional gap between hits
                if (r[21:19] == 3'd0) begin
                    idleCycle();
                end
            end else begin
                sendHit(f.pixel, f.bin);
            end
        end
        // let the last writes land before frameEnd
        idleCycle();
        idleCycle();
        idleCycle();
        for (int p = 0; p < `HIST_PIXELS; p++) begin
            expPeaks[p] = expectedPeak(p);
        end
        readout();
        if (clearShadow) begin
            clearModel();
        end
    endtask

    initial begin
        res <= 1'b0;
        hitValid <= 1'b0;
        hitPixel <= '0;
        hitBin <= '0;
        frameEnd <= 1'b0;
        cfgWrite <= 1'b0;
        cfgAddr <= '0;
        cfgData <= '0;
        lcgState = 32'h4f9b;
        enableShadow = 1'b1;
        clearShadow = 1'b1;
        threshShadow = 8'd1;
        clearModel();

        // hits, random, enable, clear, threshold, pixel, bin
        frames[0] = '{16'd200, 1'b1, 1'b1, 1'b1, 8'd1, 2'd0, 4'd0};
        // same bin every cycle, forwarding path, peak right at the threshold
        frames[1] = '{16'd40, 1'b0, 1'b1, 1'b1, 8'd40, 2'd2, 4'd5};
        // saturation at the maximum count
        frames[2] = '{16'd300, 1'b0, 1'b1, 1'b1, 8'd1, 2'd1, 4'd9};
        // peak below threshold
        frames[3] = '{16'd10, 1'b0, 1'b1, 1'b1, 8'd11, 2'd3, 4'd0};
        // counts accumulate across frames 4 to 6
        frames[4] = '{16'd120, 1'b1, 1'b1, 1'b0, 8'd1, 2'd0, 4'd0};
        frames[5] = '{16'd120, 1'b1, 1'b1, 1'b0, 8'd1, 2'd0, 4'd0};
        frames[6] = '{16'd60, 1'b1, 1'b1, 1'b1, 8'd6, 2'd0, 4'd0};
        // disabled, every bin stays empty
        frames[7] = '{16'd80, 1'b1, 1'b0, 1'b1, 8'd1, 2'd0, 4'd0};
        frames[8] = '{16'd50, 1'b1, 1'b1, 1'b1, 8'd1, 2'd0, 4'd0};

        repeat (4) @(posedge clk);
        res <= 1'b1;
        @(posedge clk);
        for (int f = 0; f < NUM_FRAMES; f++) begin
            runFrame(frames[f]);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule
